/* Bender.yml */
package:
  name: uart_transceiver

export_include_dirs:
  - include

sources:
  - rtl/uart_pkg.sv
  - rtl/baud_controller.sv
  - rtl/synchronizer.sv
  - rtl/uart_transmitter.sv
  - rtl/uart_receiver.sv
  - rtl/uart_top.sv
  - target: test
    files:
      - verif/uart_tb.sv

/* filelist.f */
+incdir+include
rtl/uart_pkg.sv
rtl/baud_controller.sv
rtl/synchronizer.sv
rtl/uart_transmitter.sv
rtl/uart_receiver.sv
rtl/uart_top.sv
verif/uart_tb.sv

/* include/uart_settings.svh */
/*
 * Build-time settings for the UART transceiver.
 * Holds the system clock rate, the frame shape and the tick divisors
 * of the eight selectable baud rates. Include it wherever these are needed.
 */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// system clock in Hz
`define UART_CLK_HZ 100000000

// ticks per bit, the receiver centres on half of this
`define UART_OVERSAMPLE 16

// data bits per frame, sent lsb first
`define UART_DATA_BITS 8

// clock cycles per oversampling tick, integer division rounds down
`define UART_DIV_0 (`UART_CLK_HZ / (300 * `UART_OVERSAMPLE))
`define UART_DIV_1 (`UART_CLK_HZ / (1200 * `UART_OVERSAMPLE))
`define UART_DIV_2 (`UART_CLK_HZ / (4800 * `UART_OVERSAMPLE))
`define UART_DIV_3 (`UART_CLK_HZ / (9600 * `UART_OVERSAMPLE))
`define UART_DIV_4 (`UART_CLK_HZ / (19200 * `UART_OVERSAMPLE))
`define UART_DIV_5 (`UART_CLK_HZ / (38400 * `UART_OVERSAMPLE))
`define UART_DIV_6 (`UART_CLK_HZ / (57600 * `UART_OVERSAMPLE))
`define UART_DIV_7 (`UART_CLK_HZ / (115200 * `UART_OVERSAMPLE))

// 300 baud gives the largest divisor, 20833, so 16 counter bits suffice

`endif

/* rtl/baud_controller.sv */
/*
 * Oversampling tick generator.
 * Emits a one-cycle tick every divisor cycles, the divisor picked from
 * the baud select. The count restarts whenever the select changes.
 */
`timescale 1ns/1ps
`include "uart_settings.svh"

module baud_controller (
  input  logic                Rx_sample_ENABLE,
  input  logic                reset,
  input  uart_pkg::baud_sel_t baud_select,
  output logic                tick
);

  logic [15:0]         divisor;   // cycles per tick for the current rate
  logic [15:0]         count;     // down-counter, tick on zero
  uart_pkg::baud_sel_t prev_sel;  // select seen last cycle

  always_comb
  begin
    case (baud_select)
      uart_pkg::BAUD_300:    divisor = 16'(`UART_DIV_0);
      uart_pkg::BAUD_1200:   divisor = 16'(`UART_DIV_1);
      uart_pkg::BAUD_4800:   divisor = 16'(`UART_DIV_2);
      uart_pkg::BAUD_9600:   divisor = 16'(`UART_DIV_3);
      uart_pkg::BAUD_19200:  divisor = 16'(`UART_DIV_4);
      uart_pkg::BAUD_38400:  divisor = 16'(`UART_DIV_5);
      uart_pkg::BAUD_57600:  divisor = 16'(`UART_DIV_6);
      default:               divisor = 16'(`UART_DIV_7);
    endcase
  end

  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      count    <= '0;
      prev_sel <= uart_pkg::BAUD_300;
      tick     <= 1'b0;
    end
    else
    begin
      prev_sel <= baud_select;
      if (baud_select != prev_sel)
      begin
        count <= divisor - 16'd1;  // new rate, start a full period over
        tick  <= 1'b0;
      end
      else if (count == 16'd0)
      begin
        count <= divisor - 16'd1;  // wrap
        tick  <= 1'b1;             // one cycle wide
      end
      else
      begin
        count <= count - 16'd1;
        tick  <= 1'b0;
      end
    end
  end

endmodule

/* rtl/synchronizer.sv */
/*
 * Two-flop synchronizer for the asynchronous serial input.
 * Both stages reset high, the idle level of the line, so that leaving
 * reset is never taken as a start bit. Output lags the input by two cycles.
 */
`timescale 1ns/1ps

module synchronizer (
  input  logic Rx_sample_ENABLE,
  input  logic reset,
  input  logic async_in,
  output logic sync_out
);

  logic meta;  // first stage, may go metastable

  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      meta     <= 1'b1;  // idle line
      sync_out <= 1'b1;
    end
    else
    begin
      meta     <= async_in;
      sync_out <= meta;  // settled copy
    end
  end

endmodule

/* rtl/uart_pkg.sv */
/*
 * Shared types of the UART transceiver.
 * Baud rate select, FSM state encodings and the data word.
 * Referenced by scoped name from the RTL and the testbench.
 */
`include "uart_settings.svh"

package uart_pkg;

  // the eight rates, index matches UART_DIV_n
  typedef enum logic [2:0] {
    BAUD_300    = 3'd0,
    BAUD_1200   = 3'd1,
    BAUD_4800   = 3'd2,
    BAUD_9600   = 3'd3,
    BAUD_19200  = 3'd4,
    BAUD_38400  = 3'd5,
    BAUD_57600  = 3'd6,
    BAUD_115200 = 3'd7
  } baud_sel_t;

  typedef enum logic [2:0] {
    RX_HUNT   = 3'b000,  // waiting for a falling edge
    RX_LOCK   = 3'b001,  // counting to the start bit centre
    RX_DATA   = 3'b011,  // collecting data bits
    RX_PARITY = 3'b010,  // sampling the parity bit
    RX_STOP   = 3'b110   // sampling the stop bit
  } rx_state_t;

  typedef enum logic [2:0] {
    TX_IDLE   = 3'b000,
    TX_START  = 3'b001,
    TX_DATA   = 3'b011,
    TX_PARITY = 3'b010,
    TX_STOP   = 3'b110
  } tx_state_t;

  typedef logic [`UART_DATA_BITS-1:0] byte_t;  // one data word

endpackage

/* rtl/uart_receiver.sv */
/*
 * UART frame receiver.
 * Hunts for a falling edge on the synchronized line, locks onto the start
 * bit centre and then samples every bit one period apart. Parity and stop
 * are checked; rx_data and rx_valid update only for an error-free frame.
 * All flags are levels, cleared when the next start bit is confirmed.
 */
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_receiver (
  input  logic            Rx_sample_ENABLE,
  input  logic            reset,
  input  logic            tick,
  input  logic            rx_en,
  input  logic            rxd_sync,
  output uart_pkg::byte_t rx_data,
  output logic            rx_valid,
  output logic            rx_perror,
  output logic            rx_ferror
);

  localparam int               IDX_W     = $clog2(`UART_DATA_BITS);
  localparam logic [4:0]       HALF_LAST = 5'(`UART_OVERSAMPLE / 2 - 1);
  localparam logic [4:0]       BIT_LAST  = 5'(`UART_OVERSAMPLE - 1);
  localparam logic [IDX_W-1:0] LAST_IDX  = IDX_W'(`UART_DATA_BITS - 1);

  uart_pkg::rx_state_t state;
  logic [4:0]          tick_cnt;    // ticks since lock or last sample
  logic [IDX_W-1:0]    bit_idx;     // data bit being collected
  logic                line_prev;   // line at the previous tick, for edge detect
  logic                parity_err;  // held until the stop bit is sampled
  uart_pkg::byte_t     buffer;      // data bits shifted in lsb first
  logic                bit_sample;
  logic                data_shift;

  assign bit_sample = tick && (tick_cnt == BIT_LAST);  // centre of a later bit
  assign data_shift = rx_en && bit_sample && (state == uart_pkg::RX_DATA);

  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      state      <= uart_pkg::RX_HUNT;
      tick_cnt   <= '0;
      bit_idx    <= '0;
      line_prev  <= 1'b1;
      parity_err <= 1'b0;
      rx_data    <= '0;
      rx_valid   <= 1'b0;
      rx_perror  <= 1'b0;
      rx_ferror  <= 1'b0;
    end
    else if (!rx_en)
    begin
      state     <= uart_pkg::RX_HUNT;  // held idle, outputs keep their values
      tick_cnt  <= '0;
      bit_idx   <= '0;
      line_prev <= rxd_sync;           // track the line so enabling mid-frame finds no edge
    end
    else if (tick)
    begin
      case (state)
        uart_pkg::RX_HUNT:
        begin
          line_prev <= rxd_sync;
          if (line_prev && !rxd_sync)  // falling edge
          begin
            state    <= uart_pkg::RX_LOCK;
            tick_cnt <= '0;
          end
        end
        uart_pkg::RX_LOCK:
        begin
          if (tick_cnt == HALF_LAST)   // 8 ticks in, start bit centre
          begin
            tick_cnt <= '0;
            if (rxd_sync)
            begin
              state     <= uart_pkg::RX_HUNT;  // glitch, line already back high
              line_prev <= 1'b1;
            end
            else
            begin
              state     <= uart_pkg::RX_DATA;
              bit_idx   <= '0;
              rx_valid  <= 1'b0;   // new frame confirmed, drop last status
              rx_perror <= 1'b0;
              rx_ferror <= 1'b0;
            end
          end
          else
            tick_cnt <= tick_cnt + 5'd1;
        end
        uart_pkg::RX_DATA:
        begin
          if (bit_sample)
          begin
            tick_cnt <= '0;
            if (bit_idx == LAST_IDX)
              state <= uart_pkg::RX_PARITY;
            else
              bit_idx <= bit_idx + 1'b1;
          end
          else
            tick_cnt <= tick_cnt + 5'd1;
        end
        uart_pkg::RX_PARITY:
        begin
          if (bit_sample)
          begin
            tick_cnt   <= '0;
            parity_err <= (rxd_sync != ^buffer);  // even parity expected
            state      <= uart_pkg::RX_STOP;
          end
          else
            tick_cnt <= tick_cnt + 5'd1;
        end
        uart_pkg::RX_STOP:
        begin
          if (bit_sample)
          begin
            tick_cnt  <= '0;
            rx_perror <= parity_err;
            rx_ferror <= !rxd_sync;          // stop bit must be high
            if (!parity_err && rxd_sync)
            begin
              rx_valid <= 1'b1;
              rx_data  <= buffer;            // only a clean frame reaches the user
            end
            state     <= uart_pkg::RX_HUNT;
            line_prev <= rxd_sync;           // a low stop bit is not a new edge
          end
          else
            tick_cnt <= tick_cnt + 5'd1;
        end
        default:
          state <= uart_pkg::RX_HUNT;
      endcase
    end
  end

  // newest bit enters at the top, so bit 0 ends at the bottom
  always_ff @(posedge Rx_sample_ENABLE)
  begin
    if (data_shift)
      buffer <= {rxd_sync, buffer[`UART_DATA_BITS-1:1]};
  end

endmodule

/* rtl/uart_top.sv */
/*
 * UART transceiver top level.
 * One baud controller feeds the tick to both directions; the serial input
 * passes through the synchronizer before reaching the receiver.
 */
`timescale 1ns/1ps

module uart_top (
  input  logic                Rx_sample_ENABLE,
  input  logic                reset,
  input  uart_pkg::baud_sel_t baud_select,
  input  logic                tx_en,
  input  logic                tx_wr,
  input  uart_pkg::byte_t     tx_data,
  output logic                txd,
  output logic                tx_busy,
  input  logic                rx_en,
  input  logic                rxd,
  output uart_pkg::byte_t     rx_data,
  output logic                rx_valid,
  output logic                rx_perror,
  output logic                rx_ferror
);

  logic tick;      // 16x oversampling enable, shared
  logic rxd_sync;  // serial input in the clock domain

  baud_controller baud_controller_i (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .baud_select      (baud_select),
    .tick             (tick)
  );

  synchronizer synchronizer_i (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .async_in         (rxd),
    .sync_out         (rxd_sync)
  );

  uart_transmitter uart_transmitter_i (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .tick             (tick),
    .tx_en            (tx_en),
    .tx_wr            (tx_wr),
    .tx_data          (tx_data),
    .txd              (txd),
    .tx_busy          (tx_busy)
  );

  uart_receiver uart_receiver_i (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .tick             (tick),
    .rx_en            (rx_en),
    .rxd_sync         (rxd_sync),
    .rx_data          (rx_data),
    .rx_valid         (rx_valid),
    .rx_perror        (rx_perror),
    .rx_ferror        (rx_ferror)
  );

endmodule

/* rtl/uart_transmitter.sv */
/*
 * UART frame transmitter.
 * A write is taken when tx_en is high and the transmitter is idle. The byte
 * goes out as start, eight data bits lsb first, even parity and stop, each
 * bit held for one oversampling period. tx_busy covers the whole frame.
 */
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_transmitter (
  input  logic            Rx_sample_ENABLE,
  input  logic            reset,
  input  logic            tick,
  input  logic            tx_en,
  input  logic            tx_wr,
  input  uart_pkg::byte_t tx_data,
  output logic            txd,
  output logic            tx_busy
);

  localparam int               IDX_W     = $clog2(`UART_DATA_BITS);
  localparam logic [3:0]       LAST_TICK = 4'(`UART_OVERSAMPLE - 1);
  localparam logic [IDX_W-1:0] LAST_IDX  = IDX_W'(`UART_DATA_BITS - 1);

  uart_pkg::tx_state_t state;
  logic [3:0]          tick_cnt;    // ticks into the current bit
  logic [IDX_W-1:0]    bit_idx;     // data bit being sent
  uart_pkg::byte_t     shift_reg;   // remaining data bits, lsb next
  logic                parity_bit;  // even parity of the latched byte
  logic                accept;
  logic                bit_end;
  logic                shift_next;

  assign accept  = (state == uart_pkg::TX_IDLE) && tx_en && tx_wr && !tx_busy;
  assign bit_end = tick && (tick_cnt == LAST_TICK);  // 16th tick of a bit

  // a data bit is loaded onto txd at the end of start and of every data bit but the last
  assign shift_next = bit_end &&
                      ((state == uart_pkg::TX_START) ||
                       ((state == uart_pkg::TX_DATA) && (bit_idx != LAST_IDX)));

  always_ff @(posedge Rx_sample_ENABLE or posedge reset)
  begin
    if (reset)
    begin
      state    <= uart_pkg::TX_IDLE;
      tick_cnt <= '0;
      bit_idx  <= '0;
      txd      <= 1'b1;  // line idles high
      tx_busy  <= 1'b0;
    end
    else
    begin
      case (state)
        uart_pkg::TX_IDLE:
        begin
          if (accept)
          begin
            state    <= uart_pkg::TX_START;
            tick_cnt <= '0;
            tx_busy  <= 1'b1;
          end
        end
        uart_pkg::TX_START:
        begin
          // txd still high means the start bit waits for its first tick
          if (tick && txd)
          begin
            txd      <= 1'b0;
            tick_cnt <= '0;
          end
          else if (bit_end)
          begin
            state    <= uart_pkg::TX_DATA;
            tick_cnt <= '0;
            bit_idx  <= '0;
            txd      <= shift_reg[0];  // data bit 0
          end
          else if (tick)
            tick_cnt <= tick_cnt + 4'd1;
        end
        uart_pkg::TX_DATA:
        begin
          if (bit_end)
          begin
            tick_cnt <= '0;
            if (bit_idx == LAST_IDX)
            begin
              state <= uart_pkg::TX_PARITY;
              txd   <= parity_bit;
            end
            else
            begin
              bit_idx <= bit_idx + 1'b1;
              txd     <= shift_reg[0];
            end
          end
          else if (tick)
            tick_cnt <= tick_cnt + 4'd1;
        end
        uart_pkg::TX_PARITY:
        begin
          if (bit_end)
          begin
            state    <= uart_pkg::TX_STOP;
            tick_cnt <= '0;
            txd      <= 1'b1;  // stop bit
          end
          else if (tick)
            tick_cnt <= tick_cnt + 4'd1;
        end
        uart_pkg::TX_STOP:
        begin
          if (bit_end)
          begin
            state    <= uart_pkg::TX_IDLE;  // line stays high
            tick_cnt <= '0;
            tx_busy  <= 1'b0;
          end
          else if (tick)
            tick_cnt <= tick_cnt + 4'd1;
        end
        default:
          state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  // byte and parity latched at acceptance, shifted as bits go out
  always_ff @(posedge Rx_sample_ENABLE)
  begin
    if (accept)
    begin
      shift_reg  <= tx_data;
      parity_bit <= ^tx_data;  // even parity
    end
    else if (shift_next)
      shift_reg <= shift_reg >> 1;
  end

endmodule

/* verif/uart_tb.sv */
/*
 * Testbench for the UART transceiver top level.
 * Runs loopback traffic at two rates, then bit-banged frames with parity
 * and stop-bit errors, write gating, receive gating and a line glitch.
 * Concurrent assertions do the checking; waits are bounded loops.
 */
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tb;

  localparam int CODE_VALID  = 0;  // wait codes for wait_until
  localparam int CODE_PERROR = 1;
  localparam int CODE_FERROR = 2;
  localparam int CODE_IDLE   = 3;

  logic                Rx_sample_ENABLE = 1'b0;  // low from the start, no edge at time zero
  logic                reset;
  uart_pkg::baud_sel_t baud_select;
  logic                tx_en;
  logic                tx_wr;
  uart_pkg::byte_t     tx_data;
  logic                txd;
  logic                tx_busy;
  logic                rx_en;
  logic                rxd;
  uart_pkg::byte_t     rx_data;
  logic                rx_valid;
  logic                rx_perror;
  logic                rx_ferror;

  logic                loopback;     // rxd from txd when high
  logic                bb_line;      // bit-banged serial line
  logic                bb_load;      // strobe, a good bit-banged byte is on its way
  uart_pkg::byte_t     bb_byte;
  uart_pkg::byte_t     exp_data;     // byte the next rx_valid must deliver
  logic [1:0]          bad_kind;     // 0 good, 1 parity flipped, 2 stop low
  logic                quiet;        // receiver outputs must not move
  logic                count_clear;
  logic                window_end;   // strobe, close the write-rule window
  logic                valid_q;
  int                  rise_count;   // rx_valid rises since count_clear
  int                  assert_errors;
  int                  timeouts;

  assign rxd = loopback ? txd : bb_line;  // line mux

  uart_top uart_top_i (
    .Rx_sample_ENABLE (Rx_sample_ENABLE),
    .reset            (reset),
    .baud_select      (baud_select),
    .tx_en            (tx_en),
    .tx_wr            (tx_wr),
    .tx_data          (tx_data),
    .txd              (txd),
    .tx_busy          (tx_busy),
    .rx_en            (rx_en),
    .rxd              (rxd),
    .rx_data          (rx_data),
    .rx_valid         (rx_valid),
    .rx_perror        (rx_perror),
    .rx_ferror        (rx_ferror)
  );

  initial
  begin
    forever #5 Rx_sample_ENABLE = ~Rx_sample_ENABLE;  // 100 MHz
  end

  // accepted writes and good bit-banged frames set the expected byte
  always @(posedge Rx_sample_ENABLE)
  begin
    if (!reset && tx_wr && tx_en && !tx_busy)
      exp_data <= tx_data;
    else if (bb_load)
      exp_data <= bb_byte;
    valid_q <= rx_valid;
    if (count_clear)
      rise_count <= 0;
    else if (!reset && rx_valid && !valid_q)
      rise_count <= rise_count + 1;
  end

  task automatic report_error(input string msg);
    assert_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  function automatic int bit_cycles(input uart_pkg::baud_sel_t sel);
    case (sel)
      uart_pkg::BAUD_300:   return `UART_DIV_0 * `UART_OVERSAMPLE;
      uart_pkg::BAUD_1200:  return `UART_DIV_1 * `UART_OVERSAMPLE;
      uart_pkg::BAUD_4800:  return `UART_DIV_2 * `UART_OVERSAMPLE;
      uart_pkg::BAUD_9600:  return `UART_DIV_3 * `UART_OVERSAMPLE;
      uart_pkg::BAUD_19200: return `UART_DIV_4 * `UART_OVERSAMPLE;
      uart_pkg::BAUD_38400: return `UART_DIV_5 * `UART_OVERSAMPLE;
      uart_pkg::BAUD_57600: return `UART_DIV_6 * `UART_OVERSAMPLE;
      default:              return `UART_DIV_7 * `UART_OVERSAMPLE;
    endcase
  endfunction

  function automatic logic cond_met(input int which);
    case (which)
      CODE_VALID:  return rx_valid;
      CODE_PERROR: return rx_perror;
      CODE_FERROR: return rx_ferror;
      default:     return !tx_busy;
    endcase
  endfunction

  task automatic wait_until(input int which, input int limit, input string what);
    int n;
    n = 0;
    while (!cond_met(which) && n < limit)
    begin
      @(negedge Rx_sample_ENABLE);
      n++;
    end
    if (!cond_met(which))
    begin
      timeouts++;
      $display("Timed out after %0d cycles waiting for %s", limit, what);
    end
  endtask

  // one write strobe, then the frame and its reception
  task automatic send_byte(input uart_pkg::byte_t b);
    @(negedge Rx_sample_ENABLE);
    tx_data = b;
    tx_wr   = 1'b1;
    @(negedge Rx_sample_ENABLE);
    tx_wr   = 1'b0;
    wait_until(CODE_IDLE, 12 * bit_cycles(baud_select), "the transmitter to finish");
    wait_until(CODE_VALID, bit_cycles(baud_select), "rx_valid after a loopback frame");
  endtask

  // start, 8 data lsb first, parity, stop, then one idle bit
  task automatic bang_frame(input uart_pkg::byte_t b, input logic flip, input logic stop,
                            input logic load);
    logic [10:0] bits;
    int          len;
    len  = bit_cycles(baud_select);
    bits = {stop, (^b) ^ flip, b, 1'b0};
    @(negedge Rx_sample_ENABLE);
    bad_kind = flip ? 2'd1 : (!stop ? 2'd2 : 2'd0);
    bb_byte  = b;
    bb_load  = load;
    for (int i = 0; i < 11; i++)
    begin
      bb_line = bits[i];
      @(negedge Rx_sample_ENABLE);
      bb_load = 1'b0;
      repeat (len - 1) @(negedge Rx_sample_ENABLE);
    end
    bb_line = 1'b1;
    repeat (len) @(negedge Rx_sample_ENABLE);  // idle gap
  endtask

  check_reset: assert property (@(negedge Rx_sample_ENABLE)
    (reset || $fell(reset)) |-> (txd && !tx_busy && !rx_valid && !rx_perror && !rx_ferror))
    else report_error("outputs not idle around reset");

  check_good: assert property (@(posedge Rx_sample_ENABLE) disable iff (reset)
    $rose(rx_valid) |-> (rx_data == exp_data && !rx_perror && !rx_ferror && bad_kind == 2'd0))
    else report_error("rx_valid rose with wrong data or flags");

  check_parity: assert property (@(posedge Rx_sample_ENABLE) disable iff (reset)
    $rose(rx_perror) |-> (bad_kind == 2'd1 && !rx_valid && !rx_ferror && rx_data == exp_data))
    else report_error("unexpected parity error or data change");

  check_frame: assert property (@(posedge Rx_sample_ENABLE) disable iff (reset)
    $rose(rx_ferror) |-> (bad_kind == 2'd2 && !rx_valid && !rx_perror && rx_data == exp_data))
    else report_error("unexpected framing error or data change");

  check_data_hold: assert property (@(posedge Rx_sample_ENABLE) disable iff (reset)
    !$rose(rx_valid) |-> $stable(rx_data))
    else report_error("rx_data changed without rx_valid rising");

  check_busy_rise: assert property (@(posedge Rx_sample_ENABLE) disable iff (reset)
    (tx_wr && tx_en && !tx_busy) |=> tx_busy)
    else report_error("tx_busy did not rise after an accepted write");

  check_tx_gate: assert property (@(posedge Rx_sample_ENABLE) disable iff (reset)
    (tx_wr && !tx_en && !tx_busy) |=> !tx_busy)
    else report_error("write accepted while tx_en was low");

  check_busy_span: assert property (@(posedge Rx_sample_ENABLE) disable iff (reset)
    (loopback && $rose(rx_valid)) |-> tx_busy)
    else report_error("tx_busy low while its frame was still on the line");

  check_quiet: assert property (@(posedge Rx_sample_ENABLE) disable iff (reset)
    quiet |=> ($stable(rx_valid) && $stable(rx_data) && $stable(rx_perror)
               && $stable(rx_ferror)))
    else report_error("receiver outputs moved while gated or on a glitch");

  check_window: assert property (@(posedge Rx_sample_ENABLE)
    window_end |-> rise_count == 1)
    else report_error("write rules let other than one frame through");

  initial
  begin
    reset         = 1'b1;
    baud_select   = uart_pkg::BAUD_57600;
    tx_en         = 1'b1;
    tx_wr         = 1'b0;
    tx_data       = '0;
    rx_en         = 1'b1;
    loopback      = 1'b1;
    bb_line       = 1'b1;
    bb_load       = 1'b0;
    bb_byte       = '0;
    exp_data      = '0;
    bad_kind      = 2'd0;
    quiet         = 1'b0;
    count_clear   = 1'b1;
    window_end    = 1'b0;
    valid_q       = 1'b0;
    rise_count    = 0;
    assert_errors = 0;
    timeouts      = 0;
    void'($urandom(5));
    repeat (4) @(negedge Rx_sample_ENABLE);
    reset       = 1'b0;
    count_clear = 1'b0;

    for (int i = 0; i < 4; i++)  // loopback at 57600
      send_byte(uart_pkg::byte_t'($urandom));
    baud_select = uart_pkg::BAUD_115200;
    repeat (4) @(negedge Rx_sample_ENABLE);
    for (int i = 0; i < 4; i++)  // loopback at 115200
      send_byte(uart_pkg::byte_t'($urandom));

    // one accepted write among a busy write and a gated write
    count_clear = 1'b1;
    @(negedge Rx_sample_ENABLE);
    count_clear = 1'b0;
    tx_data = 8'hA5;
    tx_wr   = 1'b1;
    @(negedge Rx_sample_ENABLE);
    tx_wr   = 1'b0;
    repeat (20) @(negedge Rx_sample_ENABLE);
    tx_data = 8'h3C;
    tx_wr   = 1'b1;  // busy, ignored
    @(negedge Rx_sample_ENABLE);
    tx_wr   = 1'b0;
    tx_en   = 1'b0;  // frame in flight still completes
    wait_until(CODE_IDLE, 12 * bit_cycles(baud_select), "the transmitter to finish");
    wait_until(CODE_VALID, bit_cycles(baud_select), "rx_valid after the accepted write");
    tx_data = 8'hC3;
    tx_wr   = 1'b1;  // gated, ignored
    @(negedge Rx_sample_ENABLE);
    tx_wr   = 1'b0;
    repeat (12 * bit_cycles(baud_select)) @(negedge Rx_sample_ENABLE);
    window_end = 1'b1;
    @(negedge Rx_sample_ENABLE);
    window_end = 1'b0;
    tx_en      = 1'b1;

    loopback = 1'b0;  // bit-banged frames from here
    bang_frame(8'h5A, 1'b1, 1'b1, 1'b0);
    wait_until(CODE_PERROR, bit_cycles(baud_select), "rx_perror");
    bang_frame(8'h96, 1'b0, 1'b1, 1'b1);
    wait_until(CODE_VALID, bit_cycles(baud_select), "rx_valid after a parity error");
    bang_frame(8'h0F, 1'b0, 1'b0, 1'b0);
    wait_until(CODE_FERROR, bit_cycles(baud_select), "rx_ferror");
    bang_frame(uart_pkg::byte_t'($urandom), 1'b0, 1'b1, 1'b1);
    wait_until(CODE_VALID, bit_cycles(baud_select), "rx_valid after a framing error");

    quiet = 1'b1;
    rx_en = 1'b0;
    bang_frame(8'h81, 1'b0, 1'b1, 1'b0);  // ignored while disabled
    rx_en = 1'b1;
    @(negedge Rx_sample_ENABLE);
    bb_line = 1'b0;  // glitch of a quarter bit
    repeat (bit_cycles(baud_select) / 4) @(negedge Rx_sample_ENABLE);
    bb_line = 1'b1;
    repeat (2 * bit_cycles(baud_select)) @(negedge Rx_sample_ENABLE);
    quiet = 1'b0;
    bang_frame(8'h42, 1'b0, 1'b1, 1'b1);
    wait_until(CODE_VALID, bit_cycles(baud_select), "rx_valid after gating and a glitch");

    repeat (10) @(negedge Rx_sample_ENABLE);
    $display("checks failed: %0d, timeouts: %0d", assert_errors, timeouts);
    if (assert_errors == 0 && timeouts == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule
